/* Makefile */
# Verilator simulation of the RV64M divider

SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = div_unit_tb
FILELIST  = compile.f
RUN_FLAGS = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+logic
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_iter_core.sv
logic/div_result_fmt.sv
logic/div_unit_top.sv
testbench/div_unit_sva.sv
testbench/div_unit_tb.sv

/* logic/div_iter_core.sv */
/*
 * Divider iteration core
 * Restoring shift-subtract division, one quotient bit per clock, over
 * a combined remainder and quotient register. Bypass jobs skip the
 * iteration and go straight to the result state.
 */
`include "div_params.svh"

module div_iter_core (
  input  logic              clk,
  input  logic              rst_n,
  input  div_pkg::div_job_t job_i,
  input  logic              job_valid_i,
  output div_pkg::div_raw_t raw_o,
  output logic              raw_valid_o,
  output logic              idle_o
);
  import div_pkg::*;

  localparam int RQ_W = 2 * `DIV_XLEN;

  core_state_e       state_q;
  cnt_t              cnt_q;
  logic [RQ_W-1:0]   rq_q;       // {remainder, quotient}
  xlen_t             dsor_q;
  logic              q_neg_q;
  logic              r_neg_q;
  div_op_e           op_q;
  logic              byp_q;
  xlen_t             byp_val_q;

  logic              load;
  logic [`DIV_XLEN:0]   part;    // upper half after the shift, 65 bits
  logic [`DIV_XLEN+1:0] diff;
  logic [RQ_W-1:0]   rq_step;

  assign load = (state_q == IDLE) & job_valid_i;

  // ====================
  // one iteration step
  // ====================
  assign part = rq_q[RQ_W-1:`DIV_XLEN-1];
  assign diff = {1'b0, part} - {2'b00, dsor_q};

  // sign of diff decides restore or keep
  assign rq_step = diff[`DIV_XLEN+1] ? {rq_q[RQ_W-2:0], 1'b0}
                                     : {diff[`DIV_XLEN-1:0], rq_q[`DIV_XLEN-2:0], 1'b1};

  // ====================
  // state machine
  // ====================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (job_valid_i) begin
            state_q <= job_i.bypass ? DONE : ITER;
            cnt_q   <= job_i.cnt;
          end
        end
        ITER: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == cnt_t'(1)) begin
            state_q <= DONE;  // last bit this cycle
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    if (load) begin
      rq_q      <= {{`DIV_XLEN{1'b0}}, job_i.dividend};
      dsor_q    <= job_i.divisor;
      q_neg_q   <= job_i.q_neg;
      r_neg_q   <= job_i.r_neg;
      op_q      <= job_i.op;
      byp_q     <= job_i.bypass;
      byp_val_q <= job_i.bypass_val;
    end else if (state_q == ITER) begin
      rq_q <= rq_step;
    end
  end

  always_comb begin
    raw_o.quot       = rq_q[`DIV_XLEN-1:0];
    raw_o.rem        = rq_q[RQ_W-1:`DIV_XLEN];
    raw_o.q_neg      = q_neg_q;
    raw_o.r_neg      = r_neg_q;
    raw_o.op         = op_q;
    raw_o.bypass     = byp_q;
    raw_o.bypass_val = byp_val_q;
  end

  assign raw_valid_o = (state_q == DONE);  // single cycle
  assign idle_o      = (state_q == IDLE);

endmodule

/* logic/div_operand_prep.sv */
/*
 * Divider input stage
 * Decodes the operation, sign-extends word operands, takes magnitudes
 * of signed operands and catches divide-by-zero and signed overflow.
 * One job is registered per accepted start strobe.
 */
`include "div_params.svh"

module div_operand_prep (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  div_pkg::div_op_e  op_i,
  input  div_pkg::xlen_t    dividend_i,
  input  div_pkg::xlen_t    divisor_i,
  input  logic              accept_i,
  output div_pkg::div_job_t job_o,
  output logic              job_valid_o
);
  import div_pkg::*;

  localparam int EXT_W = `DIV_XLEN - `DIV_WLEN;

  logic     is_word;
  logic     is_uns;
  logic     is_rem;
  xlen_t    a_ext;       // dividend, sign-extended for word forms
  xlen_t    b_ext;
  logic     a_neg;
  logic     b_neg;
  xlen_t    a_mag;
  xlen_t    b_mag;
  logic     div_zero;
  logic     div_of;
  logic     take;
  div_job_t job_d;

  // ====================
  // decode
  // ====================
  assign is_word = op_i[2];
  assign is_uns  = op_i[1];
  assign is_rem  = op_i[0];

  assign a_ext = is_word ? {{EXT_W{dividend_i[`DIV_WLEN-1]}}, dividend_i[`DIV_WLEN-1:0]}
                         : dividend_i;
  assign b_ext = is_word ? {{EXT_W{divisor_i[`DIV_WLEN-1]}}, divisor_i[`DIV_WLEN-1:0]}
                         : divisor_i;

  assign a_neg = ~is_uns & a_ext[`DIV_XLEN-1];
  assign b_neg = ~is_uns & b_ext[`DIV_XLEN-1];

  assign a_mag = a_neg ? -a_ext : a_ext;
  assign b_mag = b_neg ? -b_ext : b_ext;

  // ====================
  // exceptions
  // ====================
  always_comb begin
    if (is_word) begin
      div_zero = (divisor_i[`DIV_WLEN-1:0] == '0);  // only the low word counts
      div_of   = ~is_uns
               & (dividend_i[`DIV_WLEN-1:0] == {1'b1, {(`DIV_WLEN-1){1'b0}}})
               & (&divisor_i[`DIV_WLEN-1:0]);
    end else begin
      div_zero = (divisor_i == '0);
      div_of   = ~is_uns
               & (dividend_i == {1'b1, {(`DIV_XLEN-1){1'b0}}})
               & (&divisor_i);
    end
  end

  // ====================
  // job assembly
  // ====================
  always_comb begin
    job_d.q_neg  = a_neg ^ b_neg;
    job_d.r_neg  = a_neg;               // remainder follows the dividend
    job_d.op     = op_i;
    job_d.bypass = div_zero | div_of;

    if (is_word) begin
      job_d.dividend = {a_mag[`DIV_WLEN-1:0], {EXT_W{1'b0}}};  // top bits first
      job_d.divisor  = {{EXT_W{1'b0}}, b_mag[`DIV_WLEN-1:0]};
      job_d.cnt      = cnt_t'(`DIV_WLEN);
    end else begin
      job_d.dividend = a_mag;
      job_d.divisor  = b_mag;
      job_d.cnt      = cnt_t'(`DIV_XLEN);
    end

    if (div_zero) begin
      job_d.bypass_val = is_rem ? a_ext : '1;  // x / 0 = -1, x % 0 = x
    end else if (div_of) begin
      job_d.bypass_val = is_rem ? '0 : a_ext;  // min / -1 = min, rem 0
    end else begin
      job_d.bypass_val = '0;
    end
  end

  assign take = start_i & accept_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      job_valid_o <= 1'b0;
    end else begin
      job_valid_o <= take;  // one-cycle strobe
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      job_o <= job_d;
    end
  end

endmodule

/* logic/div_params.svh */
/*
 * Divider parameters
 * Widths of the RV64M divider datapath and the cycle limit used by
 * every bounded wait in simulation.
 */
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// ====================
// datapath widths
// ====================

// operand and result width
`define DIV_XLEN 64

// width of the divw/remw family
`define DIV_WLEN 32

// iteration counter, must hold DIV_XLEN
`define DIV_CNT_W 7

// ====================
// simulation
// ====================

// cycle limit for any wait on the unit
`define DIV_TIMEOUT 200

`endif

/* logic/div_pkg.sv */
/*
 * Divider package
 * Operation encoding, datapath vector types, core state encoding
 * and the two records passed between the divider stages.
 */
`include "div_params.svh"

package div_pkg;

  // op bits: [2] word form, [1] unsigned, [0] remainder
  typedef enum logic [2:0] {
    OP_DIV   = 3'b000,
    OP_REM   = 3'b001,
    OP_DIVU  = 3'b010,
    OP_REMU  = 3'b011,
    OP_DIVW  = 3'b100,
    OP_REMW  = 3'b101,
    OP_DIVUW = 3'b110,
    OP_REMUW = 3'b111
  } div_op_e;

  typedef logic [`DIV_XLEN-1:0]  xlen_t;  // operand / result
  typedef logic [`DIV_CNT_W-1:0] cnt_t;   // quotient bits left

  typedef enum logic [1:0] {
    IDLE = 2'b00,
    ITER = 2'b01,
    DONE = 2'b10
  } core_state_e;

  // job handed from operand prep to the core
  typedef struct packed {
    xlen_t   dividend;    // magnitude, word forms left-aligned
    xlen_t   divisor;     // magnitude
    cnt_t    cnt;         // iterations to run
    logic    q_neg;       // negate quotient at the end
    logic    r_neg;       // negate remainder at the end
    div_op_e op;
    logic    bypass;      // divide by zero or overflow
    xlen_t   bypass_val;  // architectural result for bypass
  } div_job_t;

  // raw magnitudes handed from the core to the formatter
  typedef struct packed {
    xlen_t   quot;
    xlen_t   rem;
    logic    q_neg;
    logic    r_neg;
    div_op_e op;
    logic    bypass;
    xlen_t   bypass_val;
  } div_raw_t;

endpackage

/* logic/div_result_fmt.sv */
/*
 * Divider output stage
 * Restores signs, picks quotient or remainder, sign-extends word
 * results and holds the value until the consumer accepts it.
 */
`include "div_params.svh"

module div_result_fmt (
  input  logic              clk,
  input  logic              rst_n,
  input  div_pkg::div_raw_t raw_i,
  input  logic              raw_valid_i,
  input  logic              result_ready_i,
  output div_pkg::xlen_t    result_o,
  output logic              result_valid_o,
  output logic              hold_o
);
  import div_pkg::*;

  localparam int EXT_W = `DIV_XLEN - `DIV_WLEN;

  xlen_t q_val;
  xlen_t r_val;
  xlen_t sel;
  xlen_t fmt_val;

  // ====================
  // formatting
  // ====================
  always_comb begin
    q_val = raw_i.q_neg ? -raw_i.quot : raw_i.quot;
    r_val = raw_i.r_neg ? -raw_i.rem  : raw_i.rem;
    sel   = raw_i.op[0] ? r_val : q_val;  // remainder ops

    if (raw_i.bypass) begin
      fmt_val = raw_i.bypass_val;  // already architectural
    end else if (raw_i.op[2]) begin
      fmt_val = {{EXT_W{sel[`DIV_WLEN-1]}}, sel[`DIV_WLEN-1:0]};
    end else begin
      fmt_val = sel;
    end
  end

  // ====================
  // output register
  // ====================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      result_valid_o <= 1'b0;
    end else if (raw_valid_i) begin
      result_valid_o <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_o <= 1'b0;  // taken by consumer
    end
  end

  always_ff @(posedge clk) begin
    if (raw_valid_i) begin
      result_o <= fmt_val;
    end
  end

  assign hold_o = result_valid_o;  // result still waiting

endmodule

/* logic/div_unit_top.sv */
/*
 * RV64M iterative divider
 * Chains operand prep, the restoring iteration core and the result
 * formatter, and forms the busy flag that gates new starts.
 */
module div_unit_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  div_pkg::div_op_e op_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  output logic             busy_o,
  output div_pkg::xlen_t   result_o,
  output logic             result_valid_o,
  input  logic             result_ready_i
);
  import div_pkg::*;

  div_job_t job;
  logic     job_valid;
  div_raw_t raw;
  logic     raw_valid;
  logic     core_idle;
  logic     hold;
  logic     accept;

  // one division in flight at a time
  assign busy_o = job_valid | ~core_idle | hold;
  assign accept = ~busy_o;

  div_operand_prep u_prep (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .op_i        (op_i),
    .dividend_i  (dividend_i),
    .divisor_i   (divisor_i),
    .accept_i    (accept),
    .job_o       (job),
    .job_valid_o (job_valid)
  );

  div_iter_core u_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .job_i       (job),
    .job_valid_i (job_valid),
    .raw_o       (raw),
    .raw_valid_o (raw_valid),
    .idle_o      (core_idle)
  );

  div_result_fmt u_fmt (
    .clk            (clk),
    .rst_n          (rst_n),
    .raw_i          (raw),
    .raw_valid_i    (raw_valid),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .hold_o         (hold)
  );

endmodule

/* testbench/div_unit_sva.sv */
/*
 * Divider checker
 * Reference model of the RV64M divide and remainder rules plus
 * handshake checks, bound to the divider top level.
 */
`include "div_params.svh"

module div_unit_sva (
  input logic             clk,
  input logic             rst_n,
  input logic             start_i,
  input div_pkg::div_op_e op_i,
  input div_pkg::xlen_t   dividend_i,
  input div_pkg::xlen_t   divisor_i,
  input logic             busy_o,
  input div_pkg::xlen_t   result_o,
  input logic             result_valid_o,
  input logic             result_ready_i
);
  import div_pkg::*;

  localparam int                   EXT_W = `DIV_XLEN - `DIV_WLEN;
  localparam xlen_t                MIN_X = {1'b1, {(`DIV_XLEN-1){1'b0}}};
  localparam logic [`DIV_WLEN-1:0] MIN_W = {1'b1, {(`DIV_WLEN-1){1'b0}}};

  xlen_t exp_q;            // expected result of the pending job
  logic  pending_q;
  logic  accepted;
  logic  taken;
  logic  fail_value = 1'b0;
  logic  fail_hold  = 1'b0;
  logic  fail_rise  = 1'b0;
  logic  fail_reset = 1'b0;
  logic  any_fail;

  function automatic xlen_t sext_word(logic [`DIV_WLEN-1:0] w);
    return {{EXT_W{w[`DIV_WLEN-1]}}, w};
  endfunction

  // RISC-V M results including zero divisor and overflow
  function automatic xlen_t expect_result(div_op_e op, xlen_t a, xlen_t b);
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    logic [`DIV_WLEN-1:0]        ua;
    logic [`DIV_WLEN-1:0]        ub;
    logic signed [`DIV_WLEN-1:0] swa;
    logic signed [`DIV_WLEN-1:0] swb;
    logic [`DIV_WLEN-1:0]        w;
    logic                        ovf;
    xlen_t                       r;
    sa  = a;
    sb  = b;
    ua  = a[`DIV_WLEN-1:0];
    ub  = b[`DIV_WLEN-1:0];
    swa = ua;
    swb = ub;
    ovf = (ua == MIN_W) && (ub == '1);
    w   = '0;
    r   = '0;
    case (op)
      OP_DIV:   if (b == '0) r = '1; else if (a == MIN_X && b == '1) r = a; else r = sa / sb;
      OP_REM:   if (b == '0) r = a; else if (a == MIN_X && b == '1) r = '0; else r = sa % sb;
      OP_DIVU:  if (b == '0) r = '1; else r = a / b;
      OP_REMU:  if (b == '0) r = a; else r = a % b;
      OP_DIVW:  if (ub == '0) w = '1; else if (ovf) w = ua; else w = swa / swb;
      OP_REMW:  if (ub == '0) w = ua; else if (ovf) w = '0; else w = swa % swb;
      OP_DIVUW: if (ub == '0) w = '1; else w = ua / ub;
      OP_REMUW: if (ub == '0) w = ua; else w = ua % ub;
      default:  r = '0;
    endcase
    if (op inside {OP_DIVW, OP_REMW, OP_DIVUW, OP_REMUW}) r = sext_word(w);
    return r;
  endfunction

  assign accepted = start_i & ~busy_o;
  assign taken    = result_valid_o & result_ready_i;
  assign any_fail = fail_value | fail_hold | fail_rise | fail_reset;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pending_q <= 1'b0;
    end else if (accepted) begin
      pending_q <= 1'b1;
      exp_q     <= expect_result(op_i, dividend_i, divisor_i);
    end else if (taken) begin
      pending_q <= 1'b0;
    end
  end

  // ====================
  // checks
  // ====================
  assert property (@(posedge clk) disable iff (rst_n) taken |-> (result_o == exp_q))
    else begin
      fail_value = 1'b1;
      $error("MISMATCH result_o expected %h got %h", exp_q, result_o);
    end

  assert property (@(posedge clk) disable iff (rst_n)
      (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_o) && busy_o))
    else begin
      fail_hold = 1'b1;
      $error("result changed or busy_o dropped while the consumer stalled");
    end

  assert property (@(posedge clk) disable iff (rst_n) $rose(result_valid_o) |-> pending_q)
    else begin
      fail_rise = 1'b1;
      $error("result_valid_o rose without an accepted start");
    end

  assert property (@(posedge clk) $fell(rst_n) |-> (!busy_o && !result_valid_o))
    else begin
      fail_reset = 1'b1;
      $error("busy_o or result_valid_o high right after reset");
    end

endmodule

bind div_unit_top div_unit_sva chk (.*);

/* testbench/div_unit_tb.sv */
/*
 * Divider testbench
 * Runs directed corner cases and random operations through the
 * divider with random back-pressure and stray start strobes.
 * Results are checked by the bound checker module.
 */
`include "div_params.svh"

module div_unit_tb;
  import div_pkg::*;

  localparam xlen_t MIN_X = 64'h8000_0000_0000_0000;
  localparam xlen_t MIN_W = 64'hffff_ffff_8000_0000;

  logic        clk;
  logic        rst_n;
  logic        start_i;
  div_op_e     op_i;
  xlen_t       dividend_i;
  xlen_t       divisor_i;
  logic        busy_o;
  xlen_t       result_o;
  logic        result_valid_o;
  logic        result_ready_i;
  logic [31:0] lcg_q;            // generator state

  div_unit_top uut (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return lcg_q;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  // random operand with corner values mixed in
  function automatic xlen_t pick_operand();
    logic [31:0] sel;
    xlen_t       rnd;
    sel        = next_rand();
    rnd[63:32] = next_rand();
    rnd[31:0]  = next_rand();
    case (sel[3:0])
      4'd0:    return '0;
      4'd1:    return '1;
      4'd2:    return MIN_X;
      4'd3:    return MIN_W;
      4'd4:    return 64'h0000_0000_8000_0000;
      4'd5:    return xlen_t'(sel[7:4]);              // small
      4'd6:    return -xlen_t'(sel[7:4]);
      4'd7:    return {32'h0000_0000, rnd[31:0]};
      4'd8:    return rnd >> sel[9:4];
      4'd9:    return {rnd[63:32], 32'h8000_0000};   // junk upper word
      default: return rnd;
    endcase
  endfunction

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o) begin
      @(negedge clk);
      n++;
      if (n > `DIV_TIMEOUT) report_failure("timeout: divider stayed busy");
    end
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    while (!result_valid_o) begin
      @(negedge clk);
      n++;
      if (n > `DIV_TIMEOUT) report_failure("timeout: no result after an accepted start");
    end
  endtask

  // one operation, then a stray start, a stall and the transfer
  task automatic run_op(input div_op_e op, input xlen_t a, input xlen_t b);
    logic [31:0] r;
    int          stall;
    wait_idle();
    start_i    = 1'b1;
    op_i       = op;
    dividend_i = a;
    divisor_i  = b;
    @(negedge clk);
    r          = next_rand();
    start_i    = r[0];             // ignored, unit is busy
    op_i       = div_op_e'(r[7:5]);
    dividend_i = pick_operand();
    divisor_i  = pick_operand();
    @(negedge clk);
    start_i = 1'b0;
    wait_result();
    stall = int'(r[2:1]);
    start_i = r[3];                // strobe during back-pressure
    repeat (stall) @(negedge clk);
    start_i        = 1'b0;
    result_ready_i = 1'b1;
    @(negedge clk);
    result_ready_i = 1'b0;
  endtask

  // stop at the first failed check
  always @(negedge clk) begin
    if (uut.chk.any_fail) report_failure("checker reported a failed check");
  end

  initial begin
    div_op_e     op;
    logic [31:0] r;
    lcg_q          = 32'h0a4dfe84;
    rst_n          = 1'b1;
    start_i        = 1'b0;
    op_i           = OP_DIV;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b0;

    // ====================
    // directed corners
    // ====================
    for (int k = 0; k < 8; k++) begin
      op = div_op_e'(k[2:0]);
      run_op(op, 64'd1234567, '0);
      run_op(op, MIN_X, '1);
      run_op(op, MIN_W, '1);
      run_op(op, 64'h1234_5678_8000_0000, 64'hdead_beef_ffff_ffff);
      run_op(op, 64'd7, -64'd2);
      run_op(op, -64'd7, 64'd2);
      run_op(op, 64'hffff_ffff_0000_0005, 64'h0000_0001_0000_0000);  // word divisor zero
      run_op(op, 64'd3, 64'd10);
    end

    // ====================
    // random operations
    // ====================
    for (int n = 0; n < 336; n++) begin
      r = next_rand();
      run_op(div_op_e'(r[2:0]), pick_operand(), pick_operand());
    end

    wait_idle();
    if (uut.chk.any_fail) begin
      report_failure("checker reported a failed check");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule
